// File: Bender.yml
package:
  name: mouse_core

sources:
  - files:
      - design/mouse_pkg.sv
      - design/mouse_decoder.sv
      - design/mouse_alu.sv
      - design/mouse_store_align.sv
      - design/mouse_control.sv
      - design/mouse_core.sv
  - target: test
    files:
      - bench/mouse_checker.sv
      - bench/mouse_tb.sv

// File: bench/mouse_checker.sv
/* compares bus writes and redirected fetches against the entry the testbench presents
   a read below win_adr counts as an instruction fetch */
module mouse_checker #(
  parameter logic [31:0] win_adr = 32'h0000_1000  // register window base
)(
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_vld,
  input  logic        bus_rdy,
  input  logic        bus_wen,
  input  logic [31:0] bus_adr,
  input  logic [3:0]  bus_ben,
  input  logic [31:0] bus_wdt,
  input  logic        exp_vld,    // an entry is waiting
  input  logic        exp_fetch,  // entry is a fetch redirect
  input  logic [95:0] exp_name,
  input  logic [31:0] exp_adr,    // write address, or address of the jump
  input  logic [3:0]  exp_ben,
  input  logic [31:0] exp_dat,    // write data, or next fetch address
  output logic        hit,        // entry matched this edge
  output int          err_cnt,
  output int          chk_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  int          errs = 0;
  int          chks = 0;
  logic        out_of_rst;      // one edge seen after reset
  logic [31:0] last_fetch;
  logic        trn;
  logic        fetch;

  assign trn     = bus_vld & bus_rdy & ~rst;
  assign fetch   = trn & ~bus_wen & (bus_adr < win_adr);
  assign err_cnt = errs;
  assign chk_cnt = chks;

  task automatic compare(input logic [8*12-1:0] what, input logic [31:0] exp, act);
    chks++;
    if (exp !== act) begin
      errs++;
      $display("Mismatch %0s %0s: expected %h, actual %h", exp_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // bus watch
  ////////////////////////////////////////

  always @(posedge clk) begin
    hit <= 1'b0;
    if (rst) begin
      chks++;
      if (bus_vld !== 1'b0) begin
        errs++;
        $display("ERROR: bus_vld is high while reset is asserted");
      end
      out_of_rst <= 1'b0;
      last_fetch <= '1;
    end else begin
      if (out_of_rst) begin  // vld rises on the first edge only
        chks++;
        if (bus_vld !== 1'b1) begin
          errs++;
          $display("ERROR: bus_vld dropped low after reset");
        end
      end
      out_of_rst <= 1'b1;
      if (trn && bus_wen) begin
        if (!exp_vld || exp_fetch) begin
          errs++;
          $display("ERROR: unexpected write to %h with data %h", bus_adr, bus_wdt);
        end else begin
          compare("address", exp_adr, bus_adr);
          compare("enables", {28'd0, exp_ben}, {28'd0, bus_ben});
          compare("data", exp_dat, bus_wdt);
          hit <= 1'b1;
        end
      end
      if (fetch) begin
        // fetch right after the jump or branch at exp_adr
        if (exp_vld && exp_fetch && (last_fetch == exp_adr)) begin
          compare("next fetch", exp_dat, bus_adr);
          hit <= 1'b1;
        end
        last_fetch <= bus_adr;
      end
    end
  end

endmodule

// File: bench/mouse_tb.sv
/* program and expected transfers are built at time zero and memory answers one cycle late
   read data of a transfer shows on bus_rdt just after its edge and holds until the next one */
module mouse_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [6:0] opi  = 7'b0010011;  // op_imm
  localparam logic [6:0] opr  = 7'b0110011;  // op
  localparam logic [6:0] opjr = 7'b1100111;  // jalr

  logic        clk, rst, bus_vld, bus_wen, bus_rdy;
  logic [31:0] bus_adr, bus_wdt, bus_rdt;
  logic [3:0]  bus_ben;
  logic        exp_vld, exp_fetch, hit;
  logic [95:0] exp_name;
  logic [31:0] exp_adr, exp_dat;
  logic [3:0]  exp_ben;
  int          chk_err, chk_cnt;
  logic [31:0] mem [0:2047];  // 8 KiB word memory
  int          pc_w = 0;      // next program word
  // expected transfers in order
  logic [95:0] q_name[$];
  bit          q_fetch[$];
  logic [31:0] q_adr[$], q_dat[$];
  logic [3:0]  q_ben[$];
  // branch cases {taken, f3, rs1, rs2} with x1 = x6 = 16 and x2 = -16
  logic [13:0] br_tab [12] = '{
    {1'b1, 3'd0, 5'd1, 5'd6}, {1'b0, 3'd0, 5'd1, 5'd2}, {1'b1, 3'd1, 5'd1, 5'd2},
    {1'b0, 3'd1, 5'd1, 5'd6}, {1'b1, 3'd4, 5'd2, 5'd1}, {1'b0, 3'd4, 5'd1, 5'd2},
    {1'b1, 3'd5, 5'd1, 5'd2}, {1'b0, 3'd5, 5'd2, 5'd1}, {1'b1, 3'd6, 5'd1, 5'd2},
    {1'b0, 3'd6, 5'd2, 5'd1}, {1'b1, 3'd7, 5'd2, 5'd1}, {1'b0, 3'd7, 5'd1, 5'd2}};
  logic [95:0] br_name [12] = '{"beq_t", "beq_n", "bne_t", "bne_n", "blt_t", "blt_n",
                                "bge_t", "bge_n", "bltu_t", "bltu_n", "bgeu_t", "bgeu_n"};

  ////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};  // R type too with {f7, rs2} as imm
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic place_word(input logic [31:0] w);
    mem[pc_w] = w;
    pc_w++;
  endtask

  task automatic expect_entry(input logic [95:0] name, input bit fetch,
                              input logic [31:0] adr, input logic [3:0] ben,
                              input logic [31:0] dat);
    q_name.push_back(name);
    q_fetch.push_back(fetch);
    q_adr.push_back(adr);
    q_ben.push_back(ben);
    q_dat.push_back(dat);
  endtask

  // instruction whose result lands in register rd
  task automatic reg_op(input logic [95:0] name, input logic [31:0] w,
                        input logic [4:0] rd, input logic [31:0] val);
    place_word(w);
    expect_entry(name, 1'b0, 32'h1000 + 4 * rd, 4'hf, val);
  endtask

  ////////////////////////////////////////
  // clock, memory, dut
  ////////////////////////////////////////

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (bus_vld && bus_rdy) begin
      bus_rdt <= #0.5 mem[bus_adr[12:2]];  // old content on a write
      if (bus_wen) begin
        for (int b = 0; b < 4; b++)
          if (bus_ben[b]) mem[bus_adr[12:2]][8*b +: 8] <= bus_wdt[8*b +: 8];
      end
    end
  end

  // rdy low about a third of the cycles
  initial begin
    bus_rdy = 1'b0;
    void'($urandom(32'h49e0_4f0e));
    forever begin
      @(posedge clk);
      #0.5 bus_rdy = ($urandom % 3) != 0;
    end
  end

  mouse_core #(.rst_adr (32'h0000_0000), .gpr_adr (32'h0000_1000)) uut (
    .clk, .rst, .bus_vld, .bus_wen, .bus_adr, .bus_ben, .bus_wdt, .bus_rdt, .bus_rdy
  );

  mouse_checker #(.win_adr (32'h0000_1000)) chk (
    .clk, .rst, .bus_vld, .bus_rdy, .bus_wen, .bus_adr, .bus_ben, .bus_wdt,
    .exp_vld, .exp_fetch, .exp_name, .exp_adr, .exp_ben, .exp_dat,
    .hit, .err_cnt (chk_err), .chk_cnt
  );

  ////////////////////////////////////////
  // program and run
  ////////////////////////////////////////

  initial begin
    int          cyc;
    int          tmo;
    logic [31:0] pc_b;
    tmo = 0;
    clk = 1'b0;
    rst = 1'b1;
    bus_rdt = '0;
    exp_vld = 1'b0;
    exp_fetch = 1'b0;
    exp_name = '0;
    exp_adr = '0;
    exp_ben = '0;
    exp_dat = '0;
    for (int i = 0; i < 2048; i++) mem[i] = {~i[15:0], i[15:0]};
    for (int i = 1024; i < 1056; i++) mem[i] = '0;  // x0..x31
    mem[1025] = 32'h0000_0010;
    mem[1026] = 32'hffff_fff0;
    mem[1027] = 32'h1234_5678;
    mem[1028] = 32'h0000_0800;  // store base
    mem[1029] = 32'h8765_4321;
    mem[1030] = 32'h0000_0010;
    mem[1031] = 32'hcafe_babe;
    reg_op("lui", {20'h12345, 5'd10, 7'b0110111}, 10, 32'h1234_5000);
    reg_op("auipc", {20'h00001, 5'd11, 7'b0010111}, 11, 32'h0000_1004);
    place_word({20'habcde, 5'd0, 7'b0110111});  // lui x0 writes nothing
    reg_op("addi", enc_i(12'hffd, 1, 0, 12, opi), 12, 32'h0000_000d);
    reg_op("slti", enc_i(12'hff1, 2, 2, 13, opi), 13, 32'h1);
    reg_op("sltiu", enc_i(12'hfff, 1, 3, 14, opi), 14, 32'h1);
    reg_op("xori", enc_i(12'h0ff, 3, 4, 15, opi), 15, 32'h1234_5687);
    reg_op("ori", enc_i(12'h701, 1, 6, 16, opi), 16, 32'h0000_0711);
    reg_op("andi", enc_i(12'hf00, 3, 7, 17, opi), 17, 32'h1234_5600);
    reg_op("add", enc_i({7'h00, 5'd5}, 3, 0, 18, opr), 18, 32'h9999_9999);
    reg_op("sub", enc_i({7'h20, 5'd2}, 1, 0, 19, opr), 19, 32'h0000_0020);
    reg_op("slt", enc_i({7'h00, 5'd1}, 2, 2, 20, opr), 20, 32'h1);
    reg_op("sltu", enc_i({7'h00, 5'd1}, 2, 3, 21, opr), 21, 32'h0);
    reg_op("xor", enc_i({7'h00, 5'd5}, 3, 4, 22, opr), 22, 32'h9551_1559);
    reg_op("or", enc_i({7'h00, 5'd7}, 3, 6, 23, opr), 23, 32'hdafe_fefe);
    reg_op("and", enc_i({7'h00, 5'd7}, 3, 7, 24, opr), 24, 32'h0234_1238);
    // stores of x7 / x3 around base 0x800
    for (int i = 0; i < 4; i++) begin
      place_word(enc_s(12'(i), 7, 4, 0));
      expect_entry("sb", 1'b0, 32'h800, 4'(1 << i), 32'hbebe_bebe);
    end
    place_word(enc_s(12'd4, 7, 4, 1));
    expect_entry("sh_lo", 1'b0, 32'h804, 4'b0011, 32'hbabe_babe);
    place_word(enc_s(12'd6, 7, 4, 1));
    expect_entry("sh_hi", 1'b0, 32'h804, 4'b1100, 32'hbabe_babe);
    place_word(enc_s(12'd8, 7, 4, 2));
    expect_entry("sw", 1'b0, 32'h808, 4'b1111, 32'hcafe_babe);
    place_word(enc_s(12'hffc, 3, 4, 2));
    expect_entry("sw_neg", 1'b0, 32'h7fc, 4'b1111, 32'h1234_5678);
    // each branch skips one nop when taken
    for (int i = 0; i < 12; i++) begin
      pc_b = 4 * pc_w;
      place_word(enc_b(13'd8, br_tab[i][4:0], br_tab[i][9:5], br_tab[i][12:10]));
      place_word(enc_i(12'd0, 0, 0, 0, opi));
      expect_entry(br_name[i], 1'b1, pc_b, 4'h0, br_tab[i][13] ? pc_b + 8 : pc_b + 4);
    end
    reg_op("jal", enc_j(21'd12, 25), 25, 32'h0000_00c4);
    expect_entry("jal", 1'b1, 32'h0000_00c0, 4'h0, 32'h0000_00cc);
    place_word(enc_i(12'd1, 0, 0, 26, opi));  // skipped since it would write x26
    place_word(enc_i(12'd1, 0, 0, 26, opi));
    reg_op("jalr", enc_i(12'h0d8, 1, 0, 27, opjr), 27, 32'h0000_00d0);
    expect_entry("jalr", 1'b1, 32'h0000_00cc, 4'h0, 32'h0000_00e8);
    while (pc_w < 58) place_word(enc_i(12'd1, 0, 0, 26, opi));
    reg_op("link_rd", enc_i(12'd4, 25, 0, 28, opi), 28, 32'h0000_00c8);
    place_word(enc_j(21'd0, 0));  // park in a loop
    expect_entry("park", 1'b1, 32'h0000_00ec, 4'h0, 32'h0000_00ec);

    repeat (10) @(posedge clk);
    #0.5 rst = 1'b0;
    exp_vld = 1'b1;
    for (int i = 0; i < q_adr.size(); i++) begin
      exp_name = q_name[i];
      exp_fetch = q_fetch[i];
      exp_adr = q_adr[i];
      exp_ben = q_ben[i];
      exp_dat = q_dat[i];
      cyc = 0;
      do begin
        @(posedge clk);
        #0.5 cyc++;
      end while (!hit && cyc < 2000);
      if (!hit) begin
        tmo++;
        $display("ERROR: timeout, %0s saw no matching transfer in 2000 cycles", exp_name);
        break;
      end
    end
    exp_vld = 1'b0;
    repeat (50) @(posedge clk);  // catch stray writes
    $display("errors %0d, timeouts %0d, checks %0d", chk_err, tmo, chk_cnt);
    if (chk_err == 0 && tmo == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
design/mouse_pkg.sv
design/mouse_decoder.sv
design/mouse_alu.sv
design/mouse_store_align.sv
design/mouse_control.sv
design/mouse_core.sv
bench/mouse_checker.sv
bench/mouse_tb.sv

// File: design/mouse_alu.sv
/* shared adder, bitwise unit and branch evaluator
   subtraction needs op2 already inverted and carry_in set by the caller */
module mouse_alu import mouse_pkg::*; (
  input  logic signed [xlen:0]   op1,        // 33 bit, caller extends
  input  logic signed [xlen:0]   op2,
  input  logic                   carry_in,
  input  alu_fn_t                fn,         // picks the bitwise op
  input  branch_fn_t             br_fn,
  output logic        [xlen-1:0] sum,
  output logic                   sgn,        // bit 32 of the full sum
  output logic                   zro,        // low word is zero
  output logic        [xlen-1:0] logic_out,
  output logic                   taken
);

  logic signed [xlen:0] sum_full;  // 33 bit adder result

  ////////////////////////////////////////
  // adder
  ////////////////////////////////////////

  // one adder for add, sub, compares and all address math
  assign sum_full = op1 + op2 + $signed({{xlen{1'b0}}, carry_in});

  assign sum = sum_full[xlen-1:0];
  assign sgn = sum_full[xlen];        // borrow / less-than flag
  assign zro = (sum_full[xlen-1:0] == '0);

  ////////////////////////////////////////
  // bitwise unit
  ////////////////////////////////////////

  always_comb begin
    case (fn)
      fn_and:  logic_out = op1[xlen-1:0] & op2[xlen-1:0];
      fn_or:   logic_out = op1[xlen-1:0] | op2[xlen-1:0];
      fn_xor:  logic_out = op1[xlen-1:0] ^ op2[xlen-1:0];
      default: logic_out = '0;  // adder ops take sum instead
    endcase
  end

  ////////////////////////////////////////
  // branch condition
  ////////////////////////////////////////

  // flags come from rs1 - rs2, extension set by caller
  always_comb begin
    case (br_fn)
      br_beq:  taken = zro;
      br_bne:  taken = ~zro;
      br_blt,
      br_bltu: taken = sgn;   // negative difference
      br_bge,
      br_bgeu: taken = ~sgn;
      default: taken = 1'b0;
    endcase
  end

endmodule

// File: design/mouse_control.sv
/* phase sequencer, all register file traffic goes over the bus to the gpr window
   read data must arrive the cycle after its transfer and stay until the next one */
module mouse_control import mouse_pkg::*; #(
  parameter logic [xlen-1:0] rst_adr = '0,  // first fetch address
  parameter logic [xlen-1:0] gpr_adr = '0   // register window, bits 31:7 used
)(
  input  logic                          clk,
  input  logic                          rst,
  input  logic              [xlen-1:0]  bus_rdt,
  input  logic                          bus_rdy,
  // decoder on live read data
  input  opcode_t                       bus_opc,
  input  logic          [gpr_sel_w-1:0] bus_rd,
  input  logic          [gpr_sel_w-1:0] bus_rs1,
  input  logic signed       [xlen-1:0]  bus_imm_u,
  // decoder on the instruction buffer
  input  opcode_t                       buf_opc,
  input  logic          [gpr_sel_w-1:0] buf_rd,
  input  logic          [gpr_sel_w-1:0] buf_rs2,
  input  logic                  [2:0]   buf_fn3,
  input  logic                          buf_fn7_alt,
  input  logic signed       [xlen-1:0]  buf_imm_i,
  input  logic signed       [xlen-1:0]  buf_imm_s,
  input  logic signed       [xlen-1:0]  buf_imm_b,
  input  logic signed       [xlen-1:0]  buf_imm_j,
  // alu results
  input  logic              [xlen-1:0]  alu_sum,
  input  logic                          alu_sgn,
  input  logic              [xlen-1:0]  alu_logic,
  input  logic                          alu_taken,
  // store alignment results
  input  logic              [xlen-1:0]  st_wdt,
  input  logic             [ben_w-1:0]  st_ben,
  output logic              [xlen-1:0]  inw_buf,   // to dec_buf
  output logic signed         [xlen:0]  alu_op1,
  output logic signed         [xlen:0]  alu_op2,
  output logic                          alu_carry,
  output alu_fn_t                       alu_fn,
  output branch_fn_t                    alu_br_fn,
  output logic              [xlen-1:0]  st_dat,
  output logic                  [1:0]   st_adr_lo,
  output store_fn_t                     st_fn,
  // shared bus request
  output logic                          bus_vld,
  output logic                          bus_wen,
  output logic              [xlen-1:0]  bus_adr,
  output logic             [ben_w-1:0]  bus_ben,
  output logic              [xlen-1:0]  bus_wdt
);

  phase_t            phase, phase_nxt;
  logic              bus_trn;     // handshake this cycle
  logic [xlen-1:0]   pc;          // address of instruction in inw_buf
  logic [xlen-1:0]   buf_dat;     // rs1 held across rs2 read
  logic              buf_tkn;     // branch outcome for next fetch
  logic [xlen-1:0]   opr_a;       // exec operands for op / op_imm
  logic [xlen-1:0]   opr_b;
  logic              inv_b;       // sub, slt, sltu

  // widen to 33 bit keeping sign
  function automatic logic signed [xlen:0] sext(input logic [xlen-1:0] v);
    return {v[xlen-1], v};
  endfunction

  // word address of register idx in the window
  function automatic logic [xlen-1:0] gpr_win(input logic [gpr_sel_w-1:0] idx);
    return {gpr_adr[xlen-1:gpr_sel_w+2], idx, 2'b00};
  endfunction

  assign bus_trn = bus_vld & bus_rdy;

  // function selects straight from the buffered funct3
  assign alu_fn    = alu_fn_t'(buf_fn3);
  assign alu_br_fn = branch_fn_t'(buf_fn3);
  assign st_fn     = store_fn_t'(buf_fn3);
  assign st_dat    = bus_rdt;           // rs2 data in exec
  assign st_adr_lo = alu_sum[1:0];

  // op takes rs1 from the buffer, op_imm straight off the bus
  assign opr_a = (buf_opc == opc_op) ? buf_dat : bus_rdt;
  assign opr_b = (buf_opc == opc_op) ? bus_rdt : buf_imm_i;
  assign inv_b = ((buf_opc == opc_op) && buf_fn7_alt && (alu_fn == fn_add)) ||
                 (alu_fn == fn_slt) || (alu_fn == fn_sltu);

  ////////////////////////////////////////
  // phase decode and bus request
  ////////////////////////////////////////

  always_comb begin
    phase_nxt = phase;
    alu_op1   = sext(pc);     // pc + 4 unless overridden
    alu_op2   = sext(32'd4);
    alu_carry = 1'b0;
    bus_wen   = 1'b0;
    bus_adr   = alu_sum;
    bus_ben   = '1;
    bus_wdt   = alu_sum;
    case (phase)
      ph_fetch: begin
        phase_nxt = ph_rs1;
        case (buf_opc)      // previous instruction picks the target
          opc_jal: alu_op2 = sext(buf_imm_j);
          opc_jalr: begin
            alu_op1 = sext(buf_dat);   // rs1 latched in exec
            alu_op2 = sext(buf_imm_i);
          end
          opc_branch: alu_op2 = sext(buf_tkn ? buf_imm_b : 32'd4);
          default: ;
        endcase
      end
      ph_rs1: begin
        case (bus_opc)      // word fetched last transfer
          opc_lui, opc_auipc, opc_jal: begin
            phase_nxt = ph_fetch;
            if (bus_opc == opc_auipc) alu_op2 = sext(bus_imm_u);
            bus_wen = (bus_rd != '0);  // x0 turns into a read
            bus_adr = gpr_win(bus_rd);
            bus_wdt = (bus_opc == opc_lui) ? bus_imm_u : alu_sum;
          end
          opc_op_imm, opc_jalr: begin
            phase_nxt = ph_exec;
            bus_adr   = gpr_win(bus_rs1);
          end
          default: begin    // op, branch, store
            phase_nxt = ph_rs2;
            bus_adr   = gpr_win(bus_rs1);
          end
        endcase
      end
      ph_rs2: begin
        phase_nxt = ph_exec;
        bus_adr   = gpr_win(buf_rs2);
      end
      ph_exec: begin
        phase_nxt = ph_fetch;
        case (buf_opc)
          opc_jalr: begin   // link value pc + 4
            bus_wen = (buf_rd != '0);
            bus_adr = gpr_win(buf_rd);
          end
          opc_store: begin
            alu_op1 = sext(buf_dat);
            alu_op2 = sext(buf_imm_s);
            bus_wen = 1'b1;
            bus_adr = {alu_sum[xlen-1:2], 2'b00};  // word aligned
            bus_ben = st_ben;
            bus_wdt = st_wdt;
          end
          opc_branch: begin  // rs1 - rs2, dummy reread of rs2
            alu_carry = 1'b1;
            alu_op1   = sext(buf_dat);
            alu_op2   = sext(~bus_rdt);
            if (alu_br_fn inside {br_bltu, br_bgeu}) begin
              alu_op1 = {1'b0, buf_dat};
              alu_op2 = {1'b1, ~bus_rdt};
            end
            bus_adr = gpr_win(buf_rs2);
          end
          default: begin    // op, op_imm
            alu_op1 = sext(opr_a);
            alu_op2 = sext(inv_b ? ~opr_b : opr_b);
            alu_carry = inv_b;
            if (alu_fn == fn_sltu) begin
              alu_op1 = {1'b0, opr_a};   // zero / one extend
              alu_op2 = {1'b1, ~opr_b};
            end
            bus_wen = (buf_rd != '0);
            bus_adr = gpr_win(buf_rd);
            case (alu_fn)
              fn_add:          bus_wdt = alu_sum;
              fn_slt, fn_sltu: bus_wdt = {{(xlen-1){1'b0}}, alu_sgn};
              default:         bus_wdt = alu_logic;
            endcase
          end
        endcase
      end
      default: phase_nxt = ph_fetch;
    endcase
  end

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_vld <= 1'b0;
      phase   <= ph_fetch;
      pc      <= rst_adr;
      inw_buf <= nop_word;  // jal x0, 0
      buf_tkn <= 1'b0;
    end else begin
      bus_vld <= 1'b1;      // valid for good once out of reset
      if (bus_trn) begin
        phase <= phase_nxt;
        if (phase == ph_fetch) pc      <= bus_adr;
        if (phase == ph_rs1)   inw_buf <= bus_rdt;  // fetched word
        if (phase == ph_exec)  buf_tkn <= alu_taken;
      end
    end
  end

  // rs1 lands here on the rs2 transfer, jalr base on exec
  always_ff @(posedge clk) begin
    if (bus_trn && ((phase == ph_rs2) || (phase == ph_exec))) buf_dat <= bus_rdt;
  end

endmodule

// File: design/mouse_core.sv
/* RV32I subset core with no internal register file, registers live at gpr_adr
   no loads, shifts or system instructions, a program must not use them */
module mouse_core import mouse_pkg::*; #(
  parameter logic [xlen-1:0] rst_adr = 32'h0000_0000,
  parameter logic [xlen-1:0] gpr_adr = 32'h0000_1000
)(
  input  logic             clk,
  input  logic             rst,
  output logic             bus_vld,
  output logic             bus_wen,
  output logic [xlen-1:0]  bus_adr,
  output logic [ben_w-1:0] bus_ben,
  output logic [xlen-1:0]  bus_wdt,
  input  logic [xlen-1:0]  bus_rdt,
  input  logic             bus_rdy
);

  // live bus decode, only what the rs1 phase needs
  opcode_t                     bus_opc;
  logic        [gpr_sel_w-1:0] bus_rd, bus_rs1;
  logic signed      [xlen-1:0] bus_imm_u;
  // buffered decode
  logic             [xlen-1:0] inw_buf;
  opcode_t                     buf_opc;
  logic        [gpr_sel_w-1:0] buf_rd, buf_rs2;
  logic                  [2:0] buf_fn3;
  logic                        buf_fn7_alt;
  logic signed      [xlen-1:0] buf_imm_i, buf_imm_s, buf_imm_b, buf_imm_j;
  // alu
  logic signed        [xlen:0] alu_op1, alu_op2;
  logic                        alu_carry, alu_sgn, alu_taken;
  alu_fn_t                     alu_fn;
  branch_fn_t                  alu_br_fn;
  logic             [xlen-1:0] alu_sum, alu_logic;
  // store lanes
  logic             [xlen-1:0] st_dat, st_wdt;
  logic                  [1:0] st_adr_lo;
  store_fn_t                   st_fn;
  logic            [ben_w-1:0] st_ben;

  mouse_decoder dec_bus (
    .inw (bus_rdt), .opc (bus_opc), .rd (bus_rd), .rs1 (bus_rs1), .rs2 (),
    .fn3 (), .fn7_alt (), .imm_i (), .imm_s (), .imm_b (), .imm_u (bus_imm_u), .imm_j ()
  );

  mouse_decoder dec_buf (
    .inw (inw_buf), .opc (buf_opc), .rd (buf_rd), .rs1 (), .rs2 (buf_rs2),
    .fn3 (buf_fn3), .fn7_alt (buf_fn7_alt), .imm_i (buf_imm_i), .imm_s (buf_imm_s),
    .imm_b (buf_imm_b), .imm_u (), .imm_j (buf_imm_j)
  );

  mouse_alu alu (
    .op1 (alu_op1), .op2 (alu_op2), .carry_in (alu_carry), .fn (alu_fn), .br_fn (alu_br_fn),
    .sum (alu_sum), .sgn (alu_sgn), .zro (), .logic_out (alu_logic), .taken (alu_taken)
  );

  mouse_store_align st_align (
    .rs2_dat (st_dat), .adr_lo (st_adr_lo), .fn (st_fn), .wdt (st_wdt), .ben (st_ben)
  );

  mouse_control #(.rst_adr (rst_adr), .gpr_adr (gpr_adr)) ctl (
    .clk, .rst, .bus_rdt, .bus_rdy,
    .bus_opc, .bus_rd, .bus_rs1, .bus_imm_u,
    .buf_opc, .buf_rd, .buf_rs2, .buf_fn3, .buf_fn7_alt,
    .buf_imm_i, .buf_imm_s, .buf_imm_b, .buf_imm_j,
    .alu_sum, .alu_sgn, .alu_logic, .alu_taken, .st_wdt, .st_ben, .inw_buf,
    .alu_op1, .alu_op2, .alu_carry, .alu_fn, .alu_br_fn, .st_dat, .st_adr_lo, .st_fn,
    .bus_vld, .bus_wen, .bus_adr, .bus_ben, .bus_wdt
  );

endmodule

// File: design/mouse_decoder.sv
/* field and immediate extraction from one instruction word
   purely combinational, no validity check on the opcode */
module mouse_decoder import mouse_pkg::*; (
  input  logic            [xlen-1:0]      inw,      // instruction word
  output opcode_t                         opc,
  output logic            [gpr_sel_w-1:0] rd,
  output logic            [gpr_sel_w-1:0] rs1,
  output logic            [gpr_sel_w-1:0] rs2,
  output logic            [2:0]           fn3,
  output logic                            fn7_alt,  // bit 30, sub/sra select
  output logic signed     [xlen-1:0]      imm_i,
  output logic signed     [xlen-1:0]      imm_s,
  output logic signed     [xlen-1:0]      imm_b,
  output logic signed     [xlen-1:0]      imm_u,
  output logic signed     [xlen-1:0]      imm_j
);

  ////////////////////////////////////////
  // register indexes and functions
  ////////////////////////////////////////

  assign opc     = opcode_t'(inw[6:2]);  // bits 1:0 ignored
  assign rd      = inw[11:7];
  assign rs1     = inw[19:15];
  assign rs2     = inw[24:20];
  assign fn3     = inw[14:12];
  assign fn7_alt = inw[30];

  ////////////////////////////////////////
  // immediates, all sign extended
  ////////////////////////////////////////

  // integer ops and jalr
  assign imm_i = {{20{inw[31]}}, inw[31:20]};

  // store offset, split around rd field
  assign imm_s = {{20{inw[31]}}, inw[31:25], inw[11:7]};

  // branch offset, always even
  assign imm_b = {{19{inw[31]}}, inw[31], inw[7], inw[30:25], inw[11:8], 1'b0};

  // upper immediate
  assign imm_u = {inw[31:12], 12'd0};

  // jal offset, bit order scrambled in the word
  assign imm_j = {{11{inw[31]}}, inw[31], inw[19:12], inw[20], inw[30:21], 1'b0};

endmodule

// File: design/mouse_pkg.sv
/* shared widths and encodings for the mouse core
   opcode and funct3 values follow the RV32I base map, bits 1:0 of a word are never decoded */
package mouse_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int xlen      = 32;  // data and address
  localparam int gpr_sel_w = 5;   // register index
  localparam int ben_w     = 4;   // byte lanes per word

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    opc_load   = 5'b00_000,  // kept for the map, never executed
    opc_op_imm = 5'b00_100,
    opc_auipc  = 5'b00_101,
    opc_store  = 5'b01_000,
    opc_op     = 5'b01_100,
    opc_lui    = 5'b01_101,
    opc_branch = 5'b11_000,
    opc_jalr   = 5'b11_001,
    opc_jal    = 5'b11_011,
    opc_system = 5'b11_100   // not executed either
  } opcode_t;

  // funct3 for OP and OP_IMM
  typedef enum logic [2:0] {
    fn_add  = 3'b000,  // sub when bit 30 set on OP
    fn_sl   = 3'b001,
    fn_slt  = 3'b010,
    fn_sltu = 3'b011,
    fn_xor  = 3'b100,
    fn_sr   = 3'b101,
    fn_or   = 3'b110,
    fn_and  = 3'b111
  } alu_fn_t;

  // funct3 for stores
  typedef enum logic [2:0] {
    st_sb = 3'b000,
    st_sh = 3'b001,
    st_sw = 3'b010
  } store_fn_t;

  // funct3 for branches, bit 1 picks unsigned compare
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_fn_t;

  // sequencer phases, one bus transfer each
  typedef enum logic [1:0] {
    ph_fetch,  // fetch next instruction
    ph_rs1,    // rd write for short ops, else rs1 read
    ph_rs2,    // rs2 read
    ph_exec    // execute, write back or store
  } phase_t;

  // jal x0, 0 -> first fetch lands on the reset address
  localparam logic [xlen-1:0] nop_word = {20'd0, 5'd0, opc_jal, 2'b11};

endpackage

// File: design/mouse_store_align.sv
/* lane placement for sb, sh and sw
   misaligned halves and words are not split, the low address bits are dropped */
module mouse_store_align import mouse_pkg::*; (
  input  logic      [xlen-1:0]  rs2_dat,  // store source register
  input  logic      [1:0]       adr_lo,   // byte offset in the word
  input  store_fn_t             fn,
  output logic      [xlen-1:0]  wdt,
  output logic      [ben_w-1:0] ben
);

  always_comb begin
    case (fn)
      st_sb: begin
        wdt = {4{rs2_dat[7:0]}};               // byte on every lane
        ben = ben_w'(4'b0001 << adr_lo);       // enable only its own
      end
      st_sh: begin
        wdt = {2{rs2_dat[15:0]}};
        ben = adr_lo[1] ? 4'b1100 : 4'b0011;   // upper or lower half
      end
      st_sw: begin
        wdt = rs2_dat;
        ben = '1;
      end
      default: begin
        // unused funct3, write nothing
        wdt = rs2_dat;
        ben = '0;
      end
    endcase
  end

endmodule
